/* common/hist_defs.svh */
`ifndef HIST_DEFS_SVH
`define HIST_DEFS_SVH

// --------------------------------------------------------------------------
// Histogram geometry
// --------------------------------------------------------------------------
// Bin address width and number of bins, kept consistent by hand
`define HIST_NB 6
`define HIST_BINS 64
// Counter width per bin, counts saturate at all ones
`define HIST_CW 12

// --------------------------------------------------------------------------
// Event grouping
// --------------------------------------------------------------------------
`define HIST_PIXEL_NUM 4
`define HIST_GW 8
// Reset values of the programmable group sizes
`define HIST_DATA_NUM_DEF 8
`define HIST_ACQ_NUM_DEF 3

`endif

/* common/hist_pkg.sv */
`include "hist_defs.svh"

package hist_pkg;

    // --------------------------------------------------------------------------
    // Stream payloads
    // --------------------------------------------------------------------------
    typedef struct packed {
        logic [`HIST_NB-1:0] bin;           // Time-bin address of one hit
    } hit_t;

    typedef struct packed {
        logic [`HIST_NB-1:0] bin;           // Index of the bin being read out
        logic [`HIST_CW-1:0] count;
        logic                last;          // Set on the final bin of a histogram
    } bin_out_t;

    // --------------------------------------------------------------------------
    // Configuration and control
    // --------------------------------------------------------------------------
    typedef struct packed {
        logic                enable;
        logic [`HIST_GW-1:0] data_num;      // Events per pixel
        logic [`HIST_GW-1:0] acq_num;       // Acquisitions per histogram
    } cfg_t;

    typedef enum logic [1:0] {
        REG_CTRL     = 2'd0,
        REG_DATA_NUM = 2'd1,
        REG_ACQ_NUM  = 2'd2
    } cfg_addr_e;

    typedef enum logic [1:0] {
        ST_CLEAR      = 2'd0,
        ST_COLLECT    = 2'd1,
        ST_READOUT    = 2'd2,
        ST_WAIT_EMPTY = 2'd3
    } hist_state_e;

endpackage

/* hist_builder/hist_bin_ram.sv */
`include "hist_defs.svh"
`timescale 1ns/10ps

module hist_bin_ram (
    input  logic                clk,
    input  logic                res,
    input  logic                acc_en,
    input  logic [`HIST_NB-1:0] acc_bin,
    input  logic                clr_en,
    input  logic [`HIST_NB-1:0] clr_bin,
    input  logic                rc_en,
    input  logic [`HIST_NB-1:0] rc_bin,
    output logic [`HIST_CW-1:0] rc_count
);

    logic [`HIST_CW-1:0] mem [`HIST_BINS];

    logic                acc_wr_q;
    logic [`HIST_NB-1:0] acc_bin_q;
    logic [`HIST_CW-1:0] acc_old_q;
    logic [`HIST_CW-1:0] acc_inc;
    logic                fwd;
    logic                wr_en;
    logic [`HIST_NB-1:0] wr_addr;
    logic [`HIST_CW-1:0] wr_val;

    // --------------------------------------------------------------------------
    // Accumulate read stage
    // --------------------------------------------------------------------------
    assign acc_inc = (&acc_old_q) ? acc_old_q : acc_old_q + 1'b1;   // Hold at full scale
    assign fwd     = acc_wr_q && (acc_bin_q == acc_bin);            // Same bin still in flight

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            acc_wr_q <= 1'b0;
        end else begin
            acc_wr_q <= acc_en;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_en) begin
            acc_bin_q <= acc_bin;
            acc_old_q <= fwd ? acc_inc : mem[acc_bin];
        end
    end

    // --------------------------------------------------------------------------
    // Single write port shared by accumulate, clear and read-and-clear
    // --------------------------------------------------------------------------
    always_comb begin
        wr_en   = acc_wr_q || clr_en || rc_en;
        wr_addr = rc_bin;
        wr_val  = '0;
        if (acc_wr_q) begin
            wr_addr = acc_bin_q;
            wr_val  = acc_inc;
        end else if (clr_en) begin
            wr_addr = clr_bin;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_addr] <= wr_val;
        if (rc_en) rc_count <= mem[rc_bin];     // Old value leaves as the bin is zeroed
    end

    a_port_exclusive: assert property (
        @(posedge clk) disable iff (!res)
        $onehot0({acc_en || acc_wr_q, clr_en, rc_en})
    );

endmodule

/* hist_builder/hist_builder_fsm.sv */
`include "hist_defs.svh"
`timescale 1ns/10ps

module hist_builder_fsm (
    input  logic                clk,
    input  logic                res,
    input  hist_pkg::cfg_t      cfg,
    input  logic                hit_valid,
    input  hist_pkg::hit_t      hit_data,
    output logic                hit_ready,
    output logic                acc_en,
    output logic [`HIST_NB-1:0] acc_bin,
    output logic                clr_en,
    output logic [`HIST_NB-1:0] clr_bin,
    output logic                rd_start,
    input  logic                rd_done
);
    import hist_pkg::*;

    hist_state_e         state;
    hist_state_e         state_nxt;
    logic [`HIST_NB-1:0] clr_cnt;
    logic [`HIST_GW-1:0] ev_cnt;
    logic [`HIST_GW-1:0] pix_cnt;
    logic [`HIST_GW-1:0] acq_cnt;
    logic                hist_open;
    logic [`HIST_GW-1:0] data_num_q;
    logic [`HIST_GW-1:0] acq_num_q;
    logic [`HIST_GW-1:0] data_lim;
    logic [`HIST_GW-1:0] acq_lim;
    logic                accept;
    logic                ev_last;
    logic                pix_last;
    logic                acq_last;

    assign accept = hit_valid && hit_ready;

    // Limits come from the live registers until the first event of a histogram
    assign data_lim = hist_open ? data_num_q : cfg.data_num;
    assign acq_lim  = hist_open ? acq_num_q  : cfg.acq_num;

    assign ev_last  = (ev_cnt == data_lim - 1'b1);
    assign pix_last = (pix_cnt == `HIST_GW'(`HIST_PIXEL_NUM - 1));
    assign acq_last = (acq_cnt == acq_lim - 1'b1);

    // --------------------------------------------------------------------------
    // State sequencing
    // --------------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ST_CLEAR: begin
                if (clr_cnt == `HIST_NB'(`HIST_BINS - 1)) state_nxt = ST_COLLECT;
            end
            ST_COLLECT: begin
                if (accept && ev_last && pix_last && acq_last) state_nxt = ST_WAIT_EMPTY;
            end
            ST_WAIT_EMPTY: state_nxt = ST_READOUT;   // Last accumulate write retires here
            ST_READOUT: begin
                if (rd_done) state_nxt = ST_COLLECT;
            end
            default: state_nxt = ST_CLEAR;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= ST_CLEAR;
            clr_cnt   <= '0;
            hit_ready <= 1'b0;
            clr_en    <= 1'b0;
            rd_start  <= 1'b0;
        end else begin
            state     <= state_nxt;
            hit_ready <= (state_nxt == ST_COLLECT) && (state != ST_CLEAR) && cfg.enable;
            clr_en    <= (state == ST_CLEAR);   // Clear write trails the counter by one cycle
            rd_start  <= (state == ST_WAIT_EMPTY);
            if (state == ST_CLEAR) clr_cnt <= clr_cnt + 1'b1;
        end
    end

    // --------------------------------------------------------------------------
    // Event, pixel and acquisition counters
    // --------------------------------------------------------------------------
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            ev_cnt     <= '0;
            pix_cnt    <= '0;
            acq_cnt    <= '0;
            hist_open  <= 1'b0;
            data_num_q <= '0;
            acq_num_q  <= '0;
        end else if (accept) begin
            if (!hist_open) begin
                hist_open  <= 1'b1;                  // Freeze group sizes for this histogram
                data_num_q <= cfg.data_num;
                acq_num_q  <= cfg.acq_num;
            end
            if (!ev_last) begin
                ev_cnt <= ev_cnt + 1'b1;
            end else begin
                ev_cnt <= '0;
                if (!pix_last) begin
                    pix_cnt <= pix_cnt + 1'b1;
                end else begin
                    pix_cnt <= '0;
                    if (!acq_last) begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end else begin
                        acq_cnt   <= '0;
                        hist_open <= 1'b0;
                    end
                end
            end
        end
    end

    assign acc_en  = accept;
    assign acc_bin = hit_data.bin;
    assign clr_bin = clr_cnt;

    a_ready_in_collect: assert property (
        @(posedge clk) disable iff (!res)
        hit_ready |-> (state == ST_COLLECT)
    );

    a_rd_start_pulse: assert property (
        @(posedge clk) disable iff (!res)
        rd_start |=> !rd_start
    );

endmodule

/* hw/hist_cfg_regs.sv */
`include "hist_defs.svh"
`timescale 1ns/10ps

module hist_cfg_regs (
    input  logic                clk,
    input  logic                res,
    input  logic                cfg_we,
    input  hist_pkg::cfg_addr_e cfg_addr,
    input  logic [`HIST_GW-1:0] cfg_wdata,
    output logic [`HIST_GW-1:0] cfg_rdata,
    output hist_pkg::cfg_t      cfg
);
    import hist_pkg::*;

    logic                ctrl_en;
    logic [`HIST_GW-1:0] data_num;
    logic [`HIST_GW-1:0] acq_num;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            ctrl_en  <= 1'b0;
            data_num <= `HIST_GW'(`HIST_DATA_NUM_DEF);
            acq_num  <= `HIST_GW'(`HIST_ACQ_NUM_DEF);
        end else if (cfg_we) begin
            case (cfg_addr)
                REG_CTRL: ctrl_en <= cfg_wdata[0];
                REG_DATA_NUM: begin
                    if (cfg_wdata != '0) data_num <= cfg_wdata;   // Zero would never close a pixel
                end
                REG_ACQ_NUM: begin
                    if (cfg_wdata != '0) acq_num <= cfg_wdata;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (cfg_addr)
            REG_CTRL:     cfg_rdata = {{(`HIST_GW-1){1'b0}}, ctrl_en};
            REG_DATA_NUM: cfg_rdata = data_num;
            REG_ACQ_NUM:  cfg_rdata = acq_num;
            default:      cfg_rdata = '0;
        endcase
    end

    assign cfg = '{enable: ctrl_en, data_num: data_num, acq_num: acq_num};

    // The controller relies on non-empty groups to reach the end of a histogram
    a_group_nonzero: assert property (
        @(posedge clk) disable iff (!res)
        (cfg.data_num != '0) && (cfg.acq_num != '0)
    );

endmodule

/* hw/hist_readout.sv */
`include "hist_defs.svh"
`timescale 1ns/10ps

module hist_readout (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 rd_start,
    output logic                 rd_done,
    output logic                 rc_en,
    output logic [`HIST_NB-1:0]  rc_bin,
    input  logic [`HIST_CW-1:0]  rc_count,
    output logic                 bin_valid,
    input  logic                 bin_ready,
    output hist_pkg::bin_out_t   bin_data
);

    logic                active;
    logic [`HIST_NB-1:0] idx;
    logic                pend;
    logic [`HIST_NB-1:0] pend_bin;
    logic                load;
    logic                idx_last;

    // rc_count holds until the next request, so a pending word may wait in the memory
    assign load     = pend && (!bin_valid || bin_ready);
    assign rc_en    = active && (!pend || load);
    assign rc_bin   = idx;
    assign idx_last = (idx == `HIST_NB'(`HIST_BINS - 1));

    // --------------------------------------------------------------------------
    // Bin walk
    // --------------------------------------------------------------------------
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            active <= 1'b0;
            idx    <= '0;
            pend   <= 1'b0;
        end else begin
            if (rd_start && !active) begin
                active <= 1'b1;
                idx    <= '0;
            end else if (rc_en) begin
                idx <= idx + 1'b1;
                if (idx_last) active <= 1'b0;
            end
            if (rc_en) begin
                pend <= 1'b1;
            end else if (load) begin
                pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rc_en) pend_bin <= idx;
    end

    // --------------------------------------------------------------------------
    // Output register
    // --------------------------------------------------------------------------
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            bin_valid <= 1'b0;
        end else if (load) begin
            bin_valid <= 1'b1;
        end else if (bin_ready) begin
            bin_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            bin_data.bin   <= pend_bin;
            bin_data.count <= rc_count;
            bin_data.last  <= (pend_bin == `HIST_NB'(`HIST_BINS - 1));
        end
    end

    assign rd_done = bin_valid && bin_ready && bin_data.last;

endmodule

/* hw/hist_top.sv */
`include "hist_defs.svh"
`timescale 1ns/10ps

module hist_top (
    input  logic                clk,
    input  logic                res,
    input  logic                cfg_we,
    input  hist_pkg::cfg_addr_e cfg_addr,
    input  logic [`HIST_GW-1:0] cfg_wdata,
    output logic [`HIST_GW-1:0] cfg_rdata,
    input  logic                hit_valid,
    input  hist_pkg::hit_t      hit_data,
    output logic                hit_ready,
    output logic                bin_valid,
    input  logic                bin_ready,
    output hist_pkg::bin_out_t  bin_data
);
    import hist_pkg::*;

    cfg_t                cfg;
    logic                acc_en;
    logic [`HIST_NB-1:0] acc_bin;
    logic                clr_en;
    logic [`HIST_NB-1:0] clr_bin;
    logic                rc_en;
    logic [`HIST_NB-1:0] rc_bin;
    logic [`HIST_CW-1:0] rc_count;
    logic                rd_start;
    logic                rd_done;

    hist_cfg_regs hist_cfg_regs_inst (
        .clk, .res, .cfg_we, .cfg_addr, .cfg_wdata, .cfg_rdata, .cfg
    );

    hist_builder_fsm hist_builder_fsm_inst (
        .clk, .res, .cfg, .hit_valid, .hit_data, .hit_ready,
        .acc_en, .acc_bin, .clr_en, .clr_bin, .rd_start, .rd_done
    );

    hist_bin_ram hist_bin_ram_inst (
        .clk, .res, .acc_en, .acc_bin, .clr_en, .clr_bin, .rc_en, .rc_bin, .rc_count
    );

    hist_readout hist_readout_inst (
        .clk, .res, .rd_start, .rd_done, .rc_en, .rc_bin, .rc_count,
        .bin_valid, .bin_ready, .bin_data
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the histogram testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f src.f --top-module hist_tb -Mdir obj_dir -o hist_sim \
    || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/hist_sim 2>&1)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "all tests passed" && exit 0 || exit 1

/* src.f */
+incdir+common
common/hist_pkg.sv
hw/hist_cfg_regs.sv
hist_builder/hist_builder_fsm.sv
hist_builder/hist_bin_ram.sv
hw/hist_readout.sv
hw/hist_top.sv
verif/hist_tb.sv

/* verif/hist_tb.sv */
`include "hist_defs.svh"
`timescale 1ns/10ps

module hist_tb;
    import hist_pkg::*;

    localparam int          CLK_HALF     = 4;
    localparam logic [31:0] SEED         = 32'h3665_0fc8;
    localparam int          PROBE_CYCLES = 8;
    localparam int          IDLE_CYCLES  = 200;
    localparam int          DN_PROG      = 5;
    localparam int          AN_PROG      = 2;
    localparam int          DN_SAT       = 255;
    localparam int          AN_SAT       = 5;
    localparam int          EV_DEF  = `HIST_DATA_NUM_DEF * `HIST_PIXEL_NUM * `HIST_ACQ_NUM_DEF;
    localparam int          EV_PROG = DN_PROG * `HIST_PIXEL_NUM * AN_PROG;
    localparam int          EV_SAT  = DN_SAT * `HIST_PIXEL_NUM * AN_SAT;
    localparam int          N_HIST  = 5;
    localparam int          EV_TOTAL = 2 * EV_DEF + 2 * EV_PROG + EV_SAT;
    localparam int          TIMEOUT_CYCLES = 2 * EV_TOTAL + 2 * `HIST_BINS * N_HIST + 500;

    typedef logic [`HIST_BINS-1:0][`HIST_CW-1:0] hist_vec_t;
    typedef logic [`HIST_NB-1:0]                 bin_q_t [$];

    logic                clk;
    logic                res;
    logic                cfg_we;
    cfg_addr_e           cfg_addr;
    logic [`HIST_GW-1:0] cfg_wdata;
    logic [`HIST_GW-1:0] cfg_rdata;
    logic                hit_valid;
    hit_t                hit_data;
    logic                hit_ready;
    logic                bin_valid;
    logic                bin_ready;
    bin_out_t            bin_data;

    bin_q_t              sent;
    hist_vec_t           exp_hist;
    bin_out_t            exp_word;
    logic                rand_ready = 1'b0;
    logic [`HIST_NB-1:0] rd_idx     = '0;
    int                  accepted   = 0;
    int                  hists_done = 0;
    int                  cycles     = 0;

    hist_top hist_top_inst (
        .clk, .res, .cfg_we, .cfg_addr, .cfg_wdata, .cfg_rdata,
        .hit_valid, .hit_data, .hit_ready, .bin_valid, .bin_ready, .bin_data
    );

    // ------------------------------------------------------------------------
    // Reference model and compare tasks
    // ------------------------------------------------------------------------
    function automatic hist_vec_t ref_hist(input bin_q_t hits);
        hist_vec_t           counts;
        int unsigned         tally [`HIST_BINS];
        int unsigned         full_scale;
        logic [`HIST_NB-1:0] idx;
        full_scale = 2 ** `HIST_CW - 1;
        tally      = '{default: 0};
        foreach (hits[i]) tally[hits[i]] = tally[hits[i]] + 1;
        for (int b = 0; b < `HIST_BINS; b++) begin
            idx         = `HIST_NB'(b);
            counts[idx] = `HIST_CW'((tally[idx] > full_scale) ? full_scale : tally[idx]);
        end
        return counts;
    endfunction

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_bin(input bin_out_t got, input bin_out_t exp);
        if (got !== exp) begin
            $display("FAIL %0t bin_data (bin/count/last): got %0d/%0d/%0b, expected %0d/%0d/%0b",
                     $time, got.bin, got.count, got.last, exp.bin, exp.count, exp.last);
            abort_run();
        end
    endtask

    task automatic check_count(input int got, input int exp, input string name);
        if (got != exp) begin
            $display("FAIL %0t %s: got %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg(input logic [`HIST_GW-1:0] got, input logic [`HIST_GW-1:0] exp,
                             input string name);
        if (got !== exp) begin
            $display("FAIL %0t cfg_rdata %s: got %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus tasks, all entered on a falling edge
    // ------------------------------------------------------------------------
    task automatic write_reg(input cfg_addr_e addr, input logic [`HIST_GW-1:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task automatic expect_reg(input cfg_addr_e addr, input logic [`HIST_GW-1:0] exp,
                              input string name);
        cfg_addr = addr;
        @(negedge clk);
        check_reg(cfg_rdata, exp, name);
    endtask

    task automatic make_random_bins(input int n);
        sent.delete();
        repeat (n) sent.push_back(`HIST_NB'($urandom));
    endtask

    task automatic make_fixed_bins(input int n);
        logic [`HIST_NB-1:0] bin;
        bin = `HIST_NB'($urandom);
        sent.delete();
        repeat (n) sent.push_back(bin);
    endtask

    task automatic send_hits();
        logic taken;
        foreach (sent[i]) begin
            hit_valid    = 1'b1;
            hit_data.bin = sent[i];
            taken        = 1'b0;
            while (!taken) begin
                taken = hit_ready;                  // Registered, stable until the next rise
                @(negedge clk);
            end
        end
        hit_valid = 1'b0;
    endtask

    task automatic run_hist(input int exp_events);
        int acc_start;
        int done_target;
        acc_start   = accepted;
        done_target = hists_done + 1;
        exp_hist    = ref_hist(sent);
        send_hits();
        hit_valid = 1'b1;                           // Spare event that must wait for readout
        repeat (PROBE_CYCLES) @(negedge clk);
        hit_valid = 1'b0;
        check_count(accepted - acc_start, exp_events, "accepted events");
        while (hists_done < done_target) @(negedge clk);
    endtask

    // ------------------------------------------------------------------------
    // Clock, ready pattern, monitors and timeout
    // ------------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    initial begin
        bin_ready = 1'b1;
        forever begin
            @(negedge clk);
            bin_ready = rand_ready ? 1'($urandom) : 1'b1;
        end
    end

    always @(posedge clk) begin
        if (hit_valid && hit_ready) accepted = accepted + 1;
    end

    always @(posedge clk) begin
        if (bin_valid && bin_ready) begin
            exp_word.bin   = rd_idx;
            exp_word.count = exp_hist[rd_idx];
            exp_word.last  = (rd_idx == `HIST_NB'(`HIST_BINS - 1));
            check_bin(bin_data, exp_word);
            if (exp_word.last) hists_done = hists_done + 1;
            rd_idx = rd_idx + 1'b1;                 // Wraps to bin 0 for the next histogram
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("Timeout after %0d cycles while waiting for the DUT", cycles);
                abort_run();
            end
        end
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        res       = 1'b0;
        cfg_we    = 1'b0;
        cfg_addr  = REG_CTRL;
        cfg_wdata = '0;
        hit_valid = 1'b0;
        hit_data  = '0;
        void'($urandom(SEED));
        repeat (4) @(negedge clk);
        res = 1'b1;
        @(negedge clk);

        // Default group sizes, steady readout
        expect_reg(REG_DATA_NUM, `HIST_GW'(`HIST_DATA_NUM_DEF), "data_num");
        expect_reg(REG_ACQ_NUM, `HIST_GW'(`HIST_ACQ_NUM_DEF), "acq_num");
        write_reg(REG_CTRL, `HIST_GW'(1));
        make_random_bins(EV_DEF);
        run_hist(EV_DEF);

        // Same events again with a stalling sink
        rand_ready = 1'b1;
        run_hist(EV_DEF);
        rand_ready = 1'b0;

        write_reg(REG_DATA_NUM, `HIST_GW'(DN_PROG));
        write_reg(REG_ACQ_NUM, `HIST_GW'(AN_PROG));
        expect_reg(REG_DATA_NUM, `HIST_GW'(DN_PROG), "data_num");
        expect_reg(REG_ACQ_NUM, `HIST_GW'(AN_PROG), "acq_num");
        make_random_bins(EV_PROG);
        run_hist(EV_PROG);
        make_random_bins(EV_PROG);                  // Counts must not carry over
        run_hist(EV_PROG);

        // One bin receives more hits than a counter can hold
        write_reg(REG_DATA_NUM, `HIST_GW'(DN_SAT));
        write_reg(REG_ACQ_NUM, `HIST_GW'(AN_SAT));
        expect_reg(REG_DATA_NUM, `HIST_GW'(DN_SAT), "data_num");
        expect_reg(REG_ACQ_NUM, `HIST_GW'(AN_SAT), "acq_num");
        make_fixed_bins(EV_SAT);
        run_hist(EV_SAT);

        write_reg(REG_CTRL, '0);
        expect_reg(REG_CTRL, '0, "ctrl");
        @(negedge clk);
        hit_valid = 1'b1;
        repeat (IDLE_CYCLES) begin
            if (hit_ready || bin_valid) begin
                $display("Disabled builder raised hit_ready or bin_valid");
                abort_run();
            end
            @(negedge clk);
        end
        hit_valid = 1'b0;
        write_reg(REG_DATA_NUM, '0);
        write_reg(REG_ACQ_NUM, '0);
        expect_reg(REG_DATA_NUM, `HIST_GW'(DN_SAT), "data_num");
        expect_reg(REG_ACQ_NUM, `HIST_GW'(AN_SAT), "acq_num");

        $display("all tests passed");
        $finish;
    end

endmodule
